// File: hdl/decode_pkg.sv
package decode_pkg;

    // Datapath widths
    localparam int INSTR_W    = 32; // Instruction word
    localparam int ADDR_W     = 32; // PC and immediate
    localparam int REG_W      = 32; // Register data
    localparam int REG_ADDR_W = 5;  // Register index

    // Opcode field, bits 31:25 of the instruction
    typedef enum logic [6:0] {
        OP_NOP  = 7'h00,
        OP_ADD  = 7'h01, // R-type arithmetic
        OP_SUB  = 7'h02,
        OP_AND  = 7'h03,
        OP_OR   = 7'h04,
        OP_ADDI = 7'h05, // Register plus immediate
        OP_LDW  = 7'h10, // Loads, word then byte
        OP_LDB  = 7'h11,
        OP_STW  = 7'h12, // Stores, word then byte
        OP_STB  = 7'h13,
        OP_BEQ  = 7'h30, // Compare and branch
        OP_JUMP = 7'h31  // Unconditional
    } opcode_e;

    // ALU operation for the execute stage
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0, // Also address generation
        ALU_SUB    = 3'd1, // Also branch compare
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_PASS_B = 3'd4  // Second operand straight through
    } alu_op_e;

    // Control bundle for EX, MEM and WB
    typedef struct packed {
        logic    regwrite; // WB: write the destination register
        logic    memtoreg; // WB: result from memory, else ALU
        logic    branch;   // MEM: redirect fetch
        logic    memwrite; // MEM: store
        logic    memread;  // MEM: load
        logic    byteword; // MEM: 1 word, 0 byte
        logic    alusrc;   // EX: 1 takes the immediate as operand B
        alu_op_e alu_op;   // EX: operation
        logic    illegal;  // Unknown opcode, treated as NOP
    } ctrl_t;

    // Data half of the stage output
    typedef struct packed {
        logic [ADDR_W-1:0]     pc;       // PC of this instruction
        logic [REG_W-1:0]      rs1_data; // First source operand
        logic [REG_W-1:0]      rs2_data; // Second source operand
        logic [REG_ADDR_W-1:0] dest_reg; // Write-back target
        logic [ADDR_W-1:0]     imm;      // Sign-extended immediate
    } decoded_t;

endpackage

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  decode_pkg::opcode_e opcode,
    output decode_pkg::ctrl_t   ctrl
);
    import decode_pkg::*;

    // Pure lookup on the opcode, no state
    always_comb begin
        ctrl = '0; // Default bundle is a NOP
        case (opcode)
            OP_NOP: begin
                ctrl = '0;
            end
            OP_ADD: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = ALU_ADD;
            end
            OP_SUB: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = ALU_SUB;
            end
            OP_AND: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = ALU_AND;
            end
            OP_OR: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = ALU_OR;
            end
            OP_ADDI: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;    // Operand B is the immediate
                ctrl.alu_op   = ALU_ADD;
            end
            OP_LDW, OP_LDB: begin
                ctrl.regwrite = 1'b1;
                ctrl.memtoreg = 1'b1;    // Load data goes to the register
                ctrl.memread  = 1'b1;
                ctrl.alusrc   = 1'b1;    // Base plus offset
                ctrl.alu_op   = ALU_ADD;
                ctrl.byteword = (opcode == OP_LDW);
            end
            OP_STW, OP_STB: begin
                ctrl.memwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = ALU_ADD;
                ctrl.byteword = (opcode == OP_STW);
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;   // Zero result means taken
            end
            OP_JUMP: begin
                ctrl.branch = 1'b1;
                ctrl.alusrc = 1'b1;
                ctrl.alu_op = ALU_PASS_B; // Target comes from the immediate
            end
            default: begin
                // Unknown code, no enables so it behaves as a bubble
                ctrl         = '0;
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: hdl/operand_extract.sv
`timescale 1ns/1ps

module operand_extract (
    input  logic [decode_pkg::INSTR_W-1:0]    instr,
    output decode_pkg::opcode_e               opcode,
    output logic [decode_pkg::REG_ADDR_W-1:0] src1_addr,
    output logic [decode_pkg::REG_ADDR_W-1:0] src2_addr,
    output logic [decode_pkg::REG_ADDR_W-1:0] dest_reg,
    output logic [decode_pkg::ADDR_W-1:0]     imm
);
    import decode_pkg::*;

    // Low bit of each register field
    localparam int OPC_LSB  = 25;
    localparam int DEST_LSB = 20;
    localparam int SRC1_LSB = 15;
    localparam int SRC2_LSB = 10;

    // Immediate payload widths
    localparam int IMM_S_W = 15; // Short form, bits 14:0
    localparam int IMM_B_W = 10; // Branch low part, bits 9:0

    logic [REG_ADDR_W-1:0] dest_field;
    logic [IMM_S_W-1:0]    imm_short;
    logic [IMM_B_W-1:0]    imm_branch;

    // Fixed field positions
    assign opcode     = opcode_e'(instr[INSTR_W-1:OPC_LSB]); // Unknown codes pass through
    assign dest_field = instr[DEST_LSB +: REG_ADDR_W];
    assign src1_addr  = instr[SRC1_LSB +: REG_ADDR_W];
    assign src2_addr  = instr[SRC2_LSB +: REG_ADDR_W];
    assign dest_reg   = dest_field;

    assign imm_short  = instr[IMM_S_W-1:0];
    assign imm_branch = instr[IMM_B_W-1:0];

    // Three immediate formats
    always_comb begin
        case (opcode)
            OP_BEQ: begin
                // Dest field is the top of the offset, 15 bits total
                imm = {{(ADDR_W-REG_ADDR_W-IMM_B_W){dest_field[REG_ADDR_W-1]}},
                       dest_field, imm_branch};
            end
            OP_JUMP: begin
                // 20 bit offset, dest field on top of the short immediate
                imm = {{(ADDR_W-REG_ADDR_W-IMM_S_W){dest_field[REG_ADDR_W-1]}},
                       dest_field, imm_short};
            end
            default: begin
                imm = {{(ADDR_W-IMM_S_W){imm_short[IMM_S_W-1]}}, imm_short};
            end
        endcase
    end

endmodule

// File: hdl/register_bank.sv
`timescale 1ns/1ps

module register_bank #(
    parameter int NUM_REGS = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_en,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [decode_pkg::REG_W-1:0]      wb_data,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_addr1,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_addr2,
    output logic [decode_pkg::REG_W-1:0]      rd_data1,
    output logic [decode_pkg::REG_W-1:0]      rd_data2
);
    import decode_pkg::*;

    logic [REG_W-1:0] regs [NUM_REGS];
    logic             wr_ok;

    // Register 0 and indices past the bank are never written
    assign wr_ok = wb_en && (wb_addr != '0) && (int'(wb_addr) < NUM_REGS);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // One read port, with write-through
    function automatic logic [REG_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [REG_W-1:0] data;
        if (addr == '0 || int'(addr) >= NUM_REGS) begin
            data = '0; // Hardwired zero, also for missing registers
        end else if (wr_ok && (wb_addr == addr)) begin
            data = wb_data; // Same-cycle write wins
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd_data1 = read_port(rd_addr1);
        rd_data2 = read_port(rd_addr2);
    end

endmodule

// File: hdl/decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  logic                              stall,
    input  logic                              flush,
    input  logic [decode_pkg::ADDR_W-1:0]     pc,
    input  decode_pkg::ctrl_t                 ctrl,
    input  logic [decode_pkg::REG_W-1:0]      rs1_data,
    input  logic [decode_pkg::REG_W-1:0]      rs2_data,
    input  logic [decode_pkg::REG_ADDR_W-1:0] dest_reg,
    input  logic [decode_pkg::ADDR_W-1:0]     imm,
    output logic                              out_valid,
    output decode_pkg::ctrl_t                 out_ctrl,
    output decode_pkg::decoded_t              out_dec
);
    import decode_pkg::*;

    decoded_t dec_next;
    logic     accept;

    // Gather the parallel decode results
    always_comb begin
        dec_next.pc       = pc;
        dec_next.rs1_data = rs1_data;
        dec_next.rs2_data = rs2_data;
        dec_next.dest_reg = dest_reg;
        dec_next.imm      = imm;
    end

    assign accept = in_valid && !stall;

    // Valid and control, cleared on any dead slot
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_ctrl  <= '0;
        end else if (flush) begin
            out_valid <= 1'b0; // Flush beats stall
            out_ctrl  <= '0;
        end else if (!stall) begin
            out_valid <= in_valid;
            out_ctrl  <= in_valid ? ctrl : '0; // Bubble carries no enables
        end
    end

    // Payload, only qualified by out_valid downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            out_dec <= dec_next;
        end
    end

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/1ps

module decode_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  logic [decode_pkg::INSTR_W-1:0]    instr,
    input  logic [decode_pkg::ADDR_W-1:0]     pc,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              wb_en,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [decode_pkg::REG_W-1:0]      wb_data,
    output logic                              out_valid,
    output decode_pkg::ctrl_t                 out_ctrl,
    output decode_pkg::decoded_t              out_dec
);
    import decode_pkg::*;

    opcode_e               opcode;    // Extractor to control unit
    ctrl_t                 ctrl;
    logic [REG_ADDR_W-1:0] src1_addr;
    logic [REG_ADDR_W-1:0] src2_addr;
    logic [REG_ADDR_W-1:0] dest_reg;
    logic [ADDR_W-1:0]     imm;
    logic [REG_W-1:0]      rs1_data;  // Register bank read data
    logic [REG_W-1:0]      rs2_data;

    // Field slicing and immediate
    operand_extract i_operand_extract (
        .instr     (instr),
        .opcode    (opcode),
        .src1_addr (src1_addr),
        .src2_addr (src2_addr),
        .dest_reg  (dest_reg),
        .imm       (imm)
    );

    control_unit i_control_unit (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    // Write port from write-back, reads from this stage
    register_bank #(
        .NUM_REGS (NUM_REGS)
    ) i_register_bank (
        .clk      (clk),
        .reset    (reset),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rd_addr1 (src1_addr),
        .rd_addr2 (src2_addr),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data)
    );

    decode_stage_reg i_decode_stage_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .stall     (stall),
        .flush     (flush),
        .pc        (pc),
        .ctrl      (ctrl),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dest_reg  (dest_reg),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ctrl  (out_ctrl),
        .out_dec   (out_dec)
    );

endmodule

// File: testbench/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top;
    import decode_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    CHECK_DELAY = CLK_PERIOD/2 - 2; // Just before the falling edge
    localparam int    SEED        = 25256;
    localparam string TEST_FILE   = "testbench/decode_tests.txt";

    // One line of the test file
    typedef struct packed {
        logic                  we;        // Write-back port
        logic [REG_ADDR_W-1:0] waddr;
        logic [REG_W-1:0]      wdata;
        logic                  valid;     // Fetch side
        logic [INSTR_W-1:0]    instr;
        logic [ADDR_W-1:0]     pc;
        logic                  stall;
        logic                  flush;
        logic                  exp_valid; // Expected after the next rising edge
        ctrl_t                 exp_ctrl;
        decoded_t              exp_dec;   // pc field filled in at check time
    } step_t;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic [INSTR_W-1:0]    instr;
    logic [ADDR_W-1:0]     pc;
    logic                  stall;
    logic                  flush;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [REG_W-1:0]      wb_data;
    logic                  out_valid;
    ctrl_t                 out_ctrl;
    decoded_t              out_dec;

    step_t             steps[$];
    logic [ADDR_W-1:0] accepted_pc;          // PC of the last accepted instruction
    int                step_num        = 0;
    int                watchdog_cycles = 0;
    bit                tests_loaded    = 1'b0;

    decode_top #(
        .NUM_REGS (32)
    ) i_decode_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .stall     (stall),
        .flush     (flush),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .out_ctrl  (out_ctrl),
        .out_dec   (out_dec)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("FAIL %0t ns: step %0d, %s is %h, expected %h",
                            $time, step_num, field, got, exp));
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
        if (got.regwrite !== exp.regwrite) report_mismatch("regwrite", got.regwrite, exp.regwrite);
        if (got.memtoreg !== exp.memtoreg) report_mismatch("memtoreg", got.memtoreg, exp.memtoreg);
        if (got.branch !== exp.branch)     report_mismatch("branch", got.branch, exp.branch);
        if (got.memwrite !== exp.memwrite) report_mismatch("memwrite", got.memwrite, exp.memwrite);
        if (got.memread !== exp.memread)   report_mismatch("memread", got.memread, exp.memread);
        if (got.byteword !== exp.byteword) report_mismatch("byteword", got.byteword, exp.byteword);
        if (got.alusrc !== exp.alusrc)     report_mismatch("alusrc", got.alusrc, exp.alusrc);
        if (got.alu_op !== exp.alu_op) begin
            report_mismatch("alu_op", 32'(got.alu_op), 32'(exp.alu_op));
        end
        if (got.illegal !== exp.illegal)   report_mismatch("illegal", got.illegal, exp.illegal);
    endtask

    // Payload only matters in a valid slot
    task automatic check_dec(input logic got_valid, input decoded_t got,
                             input logic exp_valid, input decoded_t exp);
        if (got_valid !== exp_valid) report_mismatch("out_valid", got_valid, exp_valid);
        if (exp_valid) begin
            if (got.pc !== exp.pc)             report_mismatch("pc", got.pc, exp.pc);
            if (got.rs1_data !== exp.rs1_data) begin
                report_mismatch("rs1_data", got.rs1_data, exp.rs1_data);
            end
            if (got.rs2_data !== exp.rs2_data) begin
                report_mismatch("rs2_data", got.rs2_data, exp.rs2_data);
            end
            if (got.dest_reg !== exp.dest_reg) begin
                report_mismatch("dest_reg", got.dest_reg, exp.dest_reg);
            end
            if (got.imm !== exp.imm)           report_mismatch("imm", got.imm, exp.imm);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          count;
        string       line;
        logic [31:0] col [16];
        step_t       st;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run({"Cannot open the test file ", TEST_FILE});
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue; // Blank or comment
                count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %b %h %h %h %h %h %h",
                                col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                col[7], col[8], col[9], col[10], col[11], col[12],
                                col[13], col[14], col[15]);
                if (count != 16) abort_run({"Malformed line in the test file: ", line});
                st                  = '0;
                st.we               = col[0][0];
                st.waddr            = col[1][REG_ADDR_W-1:0];
                st.wdata            = col[2];
                st.valid            = col[3][0];
                st.instr            = col[4];
                st.pc               = col[5];
                st.stall            = col[6][0];
                st.flush            = col[7][0];
                st.exp_valid        = col[8][0];
                st.exp_ctrl.regwrite = col[9][6]; // Flag string with regwrite first
                st.exp_ctrl.memtoreg = col[9][5];
                st.exp_ctrl.branch   = col[9][4];
                st.exp_ctrl.memwrite = col[9][3];
                st.exp_ctrl.memread  = col[9][2];
                st.exp_ctrl.byteword = col[9][1];
                st.exp_ctrl.alusrc   = col[9][0];
                st.exp_ctrl.alu_op   = alu_op_e'(col[10][2:0]);
                st.exp_ctrl.illegal  = col[11][0];
                st.exp_dec.rs1_data  = col[12];
                st.exp_dec.rs2_data  = col[13];
                st.exp_dec.dest_reg  = col[14][REG_ADDR_W-1:0];
                st.exp_dec.imm       = col[15];
                steps.push_back(st);
            end
            $fclose(fd);
            if (steps.size() == 0) abort_run("The test file holds no steps");
        end
    endtask

    // Drives one step on the falling edge
    task automatic apply_step(input step_t st);
        wb_en    = st.we;
        wb_addr  = st.waddr;
        wb_data  = st.wdata;
        in_valid = st.valid;
        if (st.valid) begin
            instr = st.instr;
        end else begin
            instr = $urandom(); // Don't care in a bubble
        end
        pc    = st.pc;
        stall = st.stall;
        flush = st.flush;
        if (st.valid && !st.stall) accepted_pc = st.pc; // Taken at the next edge
    endtask

    // Watchdog scaled to the number of steps
    initial begin
        wait (tests_loaded);
        #(watchdog_cycles * CLK_PERIOD);
        abort_run($sformatf("Timed out: the run did not end within %0d clock cycles",
                            watchdog_cycles));
    end

    initial begin
        decoded_t exp_dec;
        void'($urandom(SEED));
        reset       = 1'b1;
        in_valid    = 1'b0;
        instr       = '0;
        pc          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        accepted_pc = '0;
        load_tests();
        watchdog_cycles = steps.size() + 10;
        tests_loaded    = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_ctrl(out_ctrl, '0); // State straight out of reset
        check_dec(out_valid, out_dec, 1'b0, '0);
        foreach (steps[i]) begin
            step_num = i + 1;
            apply_step(steps[i]);
            @(posedge clk);
            #(CHECK_DELAY);
            exp_dec    = steps[i].exp_dec;
            exp_dec.pc = accepted_pc; // Held instruction keeps its own PC
            check_ctrl(out_ctrl, steps[i].exp_ctrl);
            check_dec(out_valid, out_dec, steps[i].exp_valid, exp_dec);
            @(negedge clk);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: testbench/decode_tests.txt
# we waddr wdata valid instr pc stall flush | exp: valid flags(rg mr br mw rd bw as) alu ill
# rs1 rs2 dest imm. Hex except flags (binary) and alu/ill. instr is random when valid is 0.
0 00 00000000 0 00000000 00000000 0 0 0 0000000 0 0 00000000 00000000 00 00000000
0 00 00000000 1 02719400 00000100 0 0 1 1000000 0 0 00000000 00000000 07 00001400
1 01 11111111 0 00000000 00000000 0 0 0 0000000 0 0 00000000 00000000 00 00000000
1 02 22222222 0 00000000 00000000 0 0 0 0000000 0 0 00000000 00000000 00 00000000
1 03 deadbeef 1 04408800 00000104 0 0 1 1000000 1 0 11111111 22222222 04 00000800
1 04 00000400 1 06519000 00000108 0 0 1 1000000 2 0 deadbeef 00000400 05 00001000
1 00 ffffffff 1 08600000 0000010c 0 0 1 1000000 3 0 00000000 00000000 06 00000000
0 00 00000000 1 08600400 00000110 0 0 1 1000000 3 0 00000000 11111111 06 00000400
1 05 80000001 1 0a52fff0 00000114 0 0 1 1000001 0 0 80000001 00000000 05 fffffff0
0 00 00000000 1 20808123 00000118 0 0 1 1100111 0 0 11111111 00000000 08 00000123
0 00 00000000 1 22914000 0000011c 0 0 1 1100101 0 0 22222222 00000000 09 ffffc000
0 00 00000000 1 24020c10 00000120 0 0 1 0001011 0 0 00000400 deadbeef 00 00000c10
0 00 00000000 1 260217ff 00000124 0 0 1 0001001 0 0 00000400 80000001 00 000017ff
0 00 00000000 1 61f08bf0 00000128 0 0 1 0010000 1 0 11111111 22222222 1f fffffff0
0 00 00000000 1 60218c0c 0000012c 0 0 1 0010000 1 0 deadbeef deadbeef 02 0000080c
0 00 00000000 1 63000004 00000130 0 0 1 0010001 4 0 00000000 00000000 10 fff80004
0 00 00000000 1 62309234 00000134 0 0 1 0010001 4 0 11111111 00000400 03 00019234
0 00 00000000 1 00008800 00000138 0 0 1 0000000 0 0 11111111 22222222 00 00000800
0 00 00000000 1 fe110005 0000013c 0 0 1 0000000 0 1 22222222 00000000 01 00000005
0 00 00000000 1 0c000000 00000140 0 0 1 0000000 0 1 00000000 00000000 00 00000000
# Stall, flush and bubble sequence
0 00 00000000 1 02a08800 00000144 0 0 1 1000000 0 0 11111111 22222222 0a 00000800
1 01 aaaa5555 1 04b19000 00000148 1 0 1 1000000 0 0 11111111 22222222 0a 00000800
0 00 00000000 1 04b19000 00000148 1 0 1 1000000 0 0 11111111 22222222 0a 00000800
0 00 00000000 1 04b19000 00000148 0 0 1 1000000 1 0 deadbeef 00000400 0b 00001000
0 00 00000000 1 02a08800 0000014c 1 1 0 0000000 0 0 00000000 00000000 00 00000000
0 00 00000000 1 02a08800 0000014c 1 0 0 0000000 0 0 00000000 00000000 00 00000000
0 00 00000000 1 02a08800 0000014c 0 0 1 1000000 0 0 aaaa5555 22222222 0a 00000800
0 00 00000000 0 00000000 00000000 0 0 0 0000000 0 0 00000000 00000000 00 00000000
0 00 00000000 1 20808123 00000150 0 1 0 0000000 0 0 00000000 00000000 00 00000000
0 00 00000000 0 00000000 00000000 0 0 0 0000000 0 0 00000000 00000000 00 00000000

// File: decode.f
hdl/decode_pkg.sv
hdl/control_unit.sv
hdl/operand_extract.sv
hdl/register_bank.sv
hdl/decode_stage_reg.sv
hdl/decode_top.sv
testbench/tb_decode_top.sv

// File: Bender.yml
package:
  name: decode

sources:
  - hdl/decode_pkg.sv
  - hdl/control_unit.sv
  - hdl/operand_extract.sv
  - hdl/register_bank.sv
  - hdl/decode_stage_reg.sv
  - hdl/decode_top.sv
  - target: test
    files:
      - testbench/tb_decode_top.sv
